/* verilog/fw_mem_pkg.sv */
/*
 * Firmware memory subsystem shared definitions.
 * Bus widths, address map, response and region codes.
 */

package fw_mem_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int AXI_ADDR_W = 12;
  localparam int DATA_W     = 32;
  localparam int STRB_W     = 4;
  localparam int RAM_ADDR_W = 9;

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  // RAM window spans 0x000 to 0x7ff
  localparam logic [AXI_ADDR_W-1:0] RAM_BASE      = 12'h000;
  localparam logic [AXI_ADDR_W-1:0] MODE_REG_ADDR = 12'h800;

  // Transactions allowed in flight
  localparam int MAX_OUTSTANDING = 2;

  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [DATA_W-1:0]     word_t;
  typedef logic [STRB_W-1:0]     strb_t;
  typedef logic [RAM_ADDR_W-1:0] ram_addr_t;
  typedef logic [1:0]            resp_t;
  typedef logic [1:0]            region_t;

  // AXI response codes
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Decoded target of a request
  localparam region_t REGION_RAM  = 2'd0;
  localparam region_t REGION_MODE = 2'd1;
  localparam region_t REGION_NONE = 2'd2;

endpackage

/* verilog/axil_req_stage.sv */
/*
 * AXI4-Lite request acceptance stage.
 * Arbitrates writes over reads, limits outstanding transactions
 * and registers the chosen request for the decode stage.
 */

`timescale 1ns/1ps

module axil_req_stage
  import fw_mem_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  input  logic      awvalid,
  input  logic      wvalid,
  input  logic      arvalid,
  input  axi_addr_t awaddr,
  input  axi_addr_t araddr,
  input  word_t     wdata,
  input  strb_t     wstrb,
  input  logic      resp_pop,
  output logic      awready,
  output logic      wready,
  output logic      arready,
  output logic      req_valid,
  output logic      req_write,
  output axi_addr_t req_addr,
  output word_t     req_wdata,
  output strb_t     req_strb
);

  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

  logic [CNT_W-1:0] outstanding;
  logic             has_room;
  logic             write_pending;
  logic             accept_write;
  logic             accept_read;
  logic             accept;

  // ----------------------------------------
  // Arbitration
  // ----------------------------------------
  assign has_room      = (outstanding < CNT_W'(MAX_OUTSTANDING));
  // A write needs both address and data present
  assign write_pending = awvalid && wvalid;
  assign accept_write  = write_pending && has_room;
  // Reads only when no write is waiting
  assign accept_read   = arvalid && !write_pending && has_room;
  assign accept        = accept_write || accept_read;

  assign awready = accept_write;
  assign wready  = accept_write;
  assign arready = accept_read;

  // Outstanding count rises on accept and falls on each B or R handshake
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      outstanding <= '0;
    end else begin
      case ({accept, resp_pop})
        2'b10:   outstanding <= outstanding + 1'b1;
        2'b01:   outstanding <= outstanding - 1'b1;
        default: outstanding <= outstanding;
      endcase
    end
  end

  // ----------------------------------------
  // Request register
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      req_valid <= 1'b0;
      req_write <= 1'b0;
    end else begin
      req_valid <= accept;
      req_write <= accept_write;
    end
  end

  // Request payload
  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr  <= accept_write ? awaddr : araddr;
      req_wdata <= wdata;
      // Reads carry no strobes
      req_strb  <= accept_write ? wstrb : '0;
    end
  end

  // Counter bounded by the limit, and a pop implies something in flight
  a_outstanding_max: assert property (@(posedge clk) disable iff (!reset_n)
    outstanding <= CNT_W'(MAX_OUTSTANDING));
  a_pop_in_flight: assert property (@(posedge clk) disable iff (!reset_n)
    resp_pop |-> (outstanding != '0));

endmodule

/* verilog/access_ctrl_stage.sv */
/*
 * Decode and mode control stage.
 * Maps addresses to regions, holds the sticky application-mode bit
 * and drives the RAM request and the delayed response tag.
 */

`timescale 1ns/1ps

module access_ctrl_stage
  import fw_mem_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  input  logic      req_valid,
  input  logic      req_write,
  input  axi_addr_t req_addr,
  input  word_t     req_wdata,
  input  strb_t     req_strb,
  output logic      cs,
  output strb_t     we,
  output ram_addr_t address,
  output word_t     write_data,
  output logic      fw_app_mode,
  output logic      tag_valid,
  output logic      tag_write,
  output region_t   tag_region,
  output logic      tag_mode
);

  localparam int RAM_TOP_BIT = RAM_ADDR_W + 2;

  axi_addr_t ram_offset;
  region_t   region;
  logic      mode_reg;
  logic      set_mode;

  // First tag register lines up with cs
  logic      d_valid;
  logic      d_write;
  region_t   d_region;
  logic      d_mode;

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  assign ram_offset = req_addr - RAM_BASE;

  always_comb begin
    if (ram_offset[AXI_ADDR_W-1:RAM_TOP_BIT] == '0) begin
      region = REGION_RAM;
    end else if (req_addr[AXI_ADDR_W-1:2] == MODE_REG_ADDR[AXI_ADDR_W-1:2]) begin
      // Whole word decoded with the byte offset ignored
      region = REGION_MODE;
    end else begin
      region = REGION_NONE;
    end
  end

  // Mode latches on byte 0 strobe with data bit 0 set
  assign set_mode = req_valid && req_write && (region == REGION_MODE) &&
                    req_strb[0] && req_wdata[0];

  // Sticky until reset
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      mode_reg <= 1'b0;
    end else if (set_mode) begin
      mode_reg <= 1'b1;
    end
  end

  assign fw_app_mode = mode_reg;

  // ----------------------------------------
  // RAM request
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      cs <= 1'b0;
      we <= '0;
    end else begin
      cs <= req_valid && (region == REGION_RAM);
      we <= (req_valid && req_write && (region == REGION_RAM)) ? req_strb : '0;
    end
  end

  always_ff @(posedge clk) begin
    address    <= ram_offset[RAM_TOP_BIT-1:2];
    write_data <= req_wdata;
  end

  // ----------------------------------------
  // Response tag delayed two cycles
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      d_valid   <= 1'b0;
      tag_valid <= 1'b0;
    end else begin
      d_valid   <= req_valid;
      tag_valid <= d_valid;
    end
  end

  always_ff @(posedge clk) begin
    // Mode as seen before this request
    d_write    <= req_write;
    d_region   <= region;
    d_mode     <= mode_reg;
    tag_write  <= d_write;
    tag_region <= d_region;
    tag_mode   <= d_mode;
  end

  // RAM select must come back as a RAM tag on the next cycle
  a_cs_ram_only: assert property (@(posedge clk) disable iff (!reset_n)
    cs |=> (tag_valid && (tag_region == REGION_RAM)));

endmodule

/* verilog/fw_ram.sv */
/*
 * Firmware RAM, 512 x 32 in two banks of 256 words.
 * Byte write strobes, one cycle ready, sealed in application mode.
 */

`timescale 1ns/1ps

module fw_ram
  import fw_mem_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  input  logic      fw_app_mode,
  input  logic      cs,
  input  strb_t     we,
  input  ram_addr_t address,
  input  word_t     write_data,
  output word_t     read_data,
  output logic      ready
);

  localparam int BANK_WORDS = 2 ** (RAM_ADDR_W - 1);

  word_t mem0 [BANK_WORDS];
  word_t mem1 [BANK_WORDS];

  word_t mem_read_data0;
  word_t mem_read_data1;
  logic  fw_app_cs;
  logic  bank_sel;
  logic  [RAM_ADDR_W-2:0] bank_addr;

  // Bank and read gating carried with the read data
  logic  rd_en_reg;
  logic  rd_bank_reg;
  logic  ready_reg;

  // Application mode seals off the whole array
  assign fw_app_cs = cs && !fw_app_mode;
  assign bank_sel  = address[RAM_ADDR_W-1];
  assign bank_addr = address[RAM_ADDR_W-2:0];

  // ----------------------------------------
  // Bank 0
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (fw_app_cs && !bank_sel) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (we[i]) begin
          mem0[bank_addr][i*8 +: 8] <= write_data[i*8 +: 8];
        end
      end
      mem_read_data0 <= mem0[bank_addr];
    end
  end

  // ----------------------------------------
  // Bank 1
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (fw_app_cs && bank_sel) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (we[i]) begin
          mem1[bank_addr][i*8 +: 8] <= write_data[i*8 +: 8];
        end
      end
      mem_read_data1 <= mem1[bank_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready_reg   <= 1'b0;
      rd_en_reg   <= 1'b0;
      rd_bank_reg <= 1'b0;
    end else begin
      ready_reg   <= cs;
      rd_en_reg   <= fw_app_cs;
      rd_bank_reg <= bank_sel;
    end
  end

  // Zero unless an unsealed access happened last cycle
  assign read_data = !rd_en_reg ? '0 : (rd_bank_reg ? mem_read_data1 : mem_read_data0);
  assign ready     = ready_reg;

  a_addr_known: assert property (@(posedge clk) disable iff (!reset_n)
    cs |-> !$isunknown(address));

endmodule

/* verilog/axil_resp_stage.sv */
/*
 * Response stage.
 * Builds response data and code per region and queues them in a
 * two-entry FIFO that feeds the B and R channels in order.
 */

`timescale 1ns/1ps

module axil_resp_stage
  import fw_mem_pkg::*;
(
  input  logic    clk,
  input  logic    reset_n,
  input  logic    tag_valid,
  input  logic    tag_write,
  input  region_t tag_region,
  input  logic    tag_mode,
  input  word_t   read_data,
  input  logic    ready,
  input  logic    bready,
  input  logic    rready,
  output logic    bvalid,
  output logic    rvalid,
  output resp_t   bresp,
  output resp_t   rresp,
  output word_t   rdata,
  output logic    resp_pop
);

  localparam int DEPTH = 2;

  // Queue storage for the payload
  logic  q_write [DEPTH];
  resp_t q_resp  [DEPTH];
  word_t q_data  [DEPTH];

  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       not_empty;
  logic       push;

  word_t resp_data;
  resp_t resp_code;

  // ----------------------------------------
  // Response forming
  // ----------------------------------------
  always_comb begin
    case (tag_region)
      REGION_RAM: begin
        // Sealed RAM already returns zero
        resp_data = read_data;
        resp_code = RESP_OKAY;
      end
      REGION_MODE: begin
        resp_data = {{(DATA_W-1){1'b0}}, tag_mode};
        resp_code = RESP_OKAY;
      end
      default: begin
        resp_data = '0;
        resp_code = RESP_SLVERR;
      end
    endcase
  end

  // ----------------------------------------
  // Two-entry FIFO
  // ----------------------------------------
  assign push      = tag_valid;
  assign not_empty = (count != 2'd0);
  assign resp_pop  = (bvalid && bready) || (rvalid && rready);

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= !wr_ptr;
      end
      if (resp_pop) begin
        rd_ptr <= !rd_ptr;
      end
      count <= count + {1'b0, push} - {1'b0, resp_pop};
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      q_write[wr_ptr] <= tag_write;
      q_resp[wr_ptr]  <= resp_code;
      q_data[wr_ptr]  <= resp_data;
    end
  end

  // Head routed to B or R by its write flag
  assign bvalid = not_empty && q_write[rd_ptr];
  assign rvalid = not_empty && !q_write[rd_ptr];
  assign bresp  = q_resp[rd_ptr];
  assign rresp  = q_resp[rd_ptr];
  assign rdata  = q_data[rd_ptr];

  a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
    push |-> (count != 2'd2));
  // RAM ready must line up with the delayed RAM tag
  a_ready_aligned: assert property (@(posedge clk) disable iff (!reset_n)
    ready == (tag_valid && (tag_region == REGION_RAM)));

endmodule

/* verilog/fw_mem_top.sv */
/*
 * Firmware memory subsystem top level.
 * Four-stage AXI4-Lite pipeline in front of the sealed firmware RAM.
 */

`timescale 1ns/1ps

module fw_mem_top
  import fw_mem_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  // Write address
  input  logic      awvalid,
  output logic      awready,
  input  axi_addr_t awaddr,
  // Write data
  input  logic      wvalid,
  output logic      wready,
  input  word_t     wdata,
  input  strb_t     wstrb,
  // Write response
  output logic      bvalid,
  input  logic      bready,
  output resp_t     bresp,
  // Read address
  input  logic      arvalid,
  output logic      arready,
  input  axi_addr_t araddr,
  // Read data
  output logic      rvalid,
  input  logic      rready,
  output word_t     rdata,
  output resp_t     rresp
);

  // Request stage outputs
  logic      req_valid;
  logic      req_write;
  axi_addr_t req_addr;
  word_t     req_wdata;
  strb_t     req_strb;

  // RAM request
  logic      cs;
  strb_t     we;
  ram_addr_t address;
  word_t     write_data;
  logic      fw_app_mode;
  word_t     read_data;
  logic      ready;

  // Response tag
  logic      tag_valid;
  logic      tag_write;
  region_t   tag_region;
  logic      tag_mode;
  logic      resp_pop;

  axil_req_stage u_req (
    .clk       (clk),
    .reset_n   (reset_n),
    .awvalid   (awvalid),
    .wvalid    (wvalid),
    .arvalid   (arvalid),
    .awaddr    (awaddr),
    .araddr    (araddr),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .resp_pop  (resp_pop),
    .awready   (awready),
    .wready    (wready),
    .arready   (arready),
    .req_valid (req_valid),
    .req_write (req_write),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .req_strb  (req_strb)
  );

  access_ctrl_stage u_ctrl (
    .clk         (clk),
    .reset_n     (reset_n),
    .req_valid   (req_valid),
    .req_write   (req_write),
    .req_addr    (req_addr),
    .req_wdata   (req_wdata),
    .req_strb    (req_strb),
    .cs          (cs),
    .we          (we),
    .address     (address),
    .write_data  (write_data),
    .fw_app_mode (fw_app_mode),
    .tag_valid   (tag_valid),
    .tag_write   (tag_write),
    .tag_region  (tag_region),
    .tag_mode    (tag_mode)
  );

  fw_ram u_ram (
    .clk         (clk),
    .reset_n     (reset_n),
    .fw_app_mode (fw_app_mode),
    .cs          (cs),
    .we          (we),
    .address     (address),
    .write_data  (write_data),
    .read_data   (read_data),
    .ready       (ready)
  );

  axil_resp_stage u_resp (
    .clk        (clk),
    .reset_n    (reset_n),
    .tag_valid  (tag_valid),
    .tag_write  (tag_write),
    .tag_region (tag_region),
    .tag_mode   (tag_mode),
    .read_data  (read_data),
    .ready      (ready),
    .bready     (bready),
    .rready     (rready),
    .bvalid     (bvalid),
    .rvalid     (rvalid),
    .bresp      (bresp),
    .rresp      (rresp),
    .rdata      (rdata),
    .resp_pop   (resp_pop)
  );

endmodule

/* dv/fw_mem_tb.sv */
/*
 * Firmware memory subsystem testbench.
 * Random AXI4-Lite traffic checked against a reference model.
 */

`timescale 1ns/1ps

module fw_mem_tb
  import fw_mem_pkg::*;
();

  localparam int TIMEOUT     = 100;
  localparam int HOLD_CYCLES = 8;
  localparam int N_ADDR      = 8;

  logic      clk;
  logic      reset_n;
  logic      awvalid;
  logic      awready;
  axi_addr_t awaddr;
  logic      wvalid;
  logic      wready;
  word_t     wdata;
  strb_t     wstrb;
  logic      bvalid;
  logic      bready;
  resp_t     bresp;
  logic      arvalid;
  logic      arready;
  axi_addr_t araddr;
  logic      rvalid;
  logic      rready;
  word_t     rdata;
  resp_t     rresp;

  // Reference model state
  word_t       model_mem [512];
  logic        model_mode;
  axi_addr_t   used_addr [N_ADDR];
  logic [15:0] lfsr;

  int checks;
  int errors;
  int errors_base;

  fw_mem_top DUT (
    .clk     (clk),
    .reset_n (reset_n),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp)
  );

  initial begin
    clk = 1'b0;
  end

  always #20 clk = ~clk;

  // ----------------------------------------
  // Random source
  // ----------------------------------------
  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One step per bit taken
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic rand_ram_addr(output axi_addr_t a);
    logic [31:0] v;
    rand_bits(9, v);
    a = {1'b0, v[8:0], 2'b00};
  endtask

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  task automatic model_write(input axi_addr_t a, input word_t d, input strb_t s,
                             output resp_t r);
    r = RESP_OKAY;
    if (a[11] == 1'b0) begin
      // Sealed RAM drops writes
      if (!model_mode) begin
        for (int i = 0; i < 4; i++) begin
          if (s[i]) begin
            model_mem[a[10:2]][i*8 +: 8] = d[i*8 +: 8];
          end
        end
      end
    end else if (a[11:2] == 10'h200) begin
      if (s[0] && d[0]) begin
        model_mode = 1'b1;
      end
    end else begin
      r = RESP_SLVERR;
    end
  endtask

  task automatic model_read(input axi_addr_t a, output word_t d, output resp_t r);
    r = RESP_OKAY;
    d = '0;
    if (a[11] == 1'b0) begin
      if (!model_mode) begin
        d = model_mem[a[10:2]];
      end
    end else if (a[11:2] == 10'h200) begin
      d = {31'd0, model_mode};
    end else begin
      r = RESP_SLVERR;
    end
  endtask

  // ----------------------------------------
  // Checking and reporting
  // ----------------------------------------
  task automatic check_val(input string name, input logic [31:0] exp,
                           input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %s expected %h actual %h", name, exp, got);
    end
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d errors", name, errors - errors_base);
    errors_base = errors;
  endtask

  task automatic abort_run(input string why);
    $display("Timeout, %s", why);
    $display("tests failed");
    $finish;
  endtask

  // ----------------------------------------
  // Bus driver
  // ----------------------------------------
  // Entered and left 1 ns after a rising edge
  task automatic do_reset();
    reset_n = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    reset_n    = 1'b1;
    model_mode = 1'b0;
  endtask

  task automatic issue_write(input axi_addr_t a, input word_t d, input strb_t s);
    int n;
    n       = 0;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    awaddr  = a;
    wdata   = d;
    wstrb   = s;
    @(negedge clk);
    while (!(awready && wready)) begin
      n++;
      if (n > TIMEOUT) begin
        abort_run("write request never accepted");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  task automatic issue_read(input axi_addr_t a);
    int n;
    n       = 0;
    arvalid = 1'b1;
    araddr  = a;
    @(negedge clk);
    while (!arready) begin
      n++;
      if (n > TIMEOUT) begin
        abort_run("read request never accepted");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    arvalid = 1'b0;
  endtask

  // Latency counts edges from the handshake to the rise of valid
  task automatic wait_b(output resp_t r, output int lat);
    lat = 0;
    @(negedge clk);
    while (!bvalid) begin
      lat++;
      if (lat > TIMEOUT) begin
        abort_run("no write response arrived");
      end
      @(negedge clk);
    end
    r = bresp;
    @(posedge clk);
    #1;
  endtask

  task automatic wait_r(output word_t d, output resp_t r, output int lat);
    lat = 0;
    @(negedge clk);
    while (!rvalid) begin
      lat++;
      if (lat > TIMEOUT) begin
        abort_run("no read response arrived");
      end
      @(negedge clk);
    end
    d = rdata;
    r = rresp;
    @(posedge clk);
    #1;
  endtask

  task automatic do_write(input axi_addr_t a, input word_t d, input strb_t s,
                          output int lat);
    resp_t exp_r;
    resp_t got_r;
    issue_write(a, d, s);
    wait_b(got_r, lat);
    model_write(a, d, s, exp_r);
    check_val($sformatf("bresp @%h", a), exp_r, got_r);
  endtask

  task automatic do_read(input axi_addr_t a, output int lat);
    word_t exp_d;
    word_t got_d;
    resp_t exp_r;
    resp_t got_r;
    issue_read(a);
    wait_r(got_d, got_r, lat);
    model_read(a, exp_d, exp_r);
    check_val($sformatf("rdata @%h", a), exp_d, got_d);
    check_val($sformatf("rresp @%h", a), exp_r, got_r);
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic test_ram_rw();
    logic [31:0] d;
    logic [31:0] s;
    int          lat;
    for (int i = 0; i < N_ADDR; i++) begin
      rand_ram_addr(used_addr[i]);
      rand_bits(32, d);
      // Full word first so no byte is left unknown
      do_write(used_addr[i], d, 4'hF, lat);
      rand_bits(32, d);
      rand_bits(4, s);
      do_write(used_addr[i], d, s[3:0], lat);
      do_read(used_addr[i], lat);
    end
    end_test("ram_rw");
  endtask

  task automatic test_mode_reg();
    int lat;
    do_read(MODE_REG_ADDR, lat);
    do_write(MODE_REG_ADDR, 32'h1, 4'h1, lat);
    do_read(MODE_REG_ADDR, lat);
    // A zero write leaves the sticky bit set
    do_write(MODE_REG_ADDR, 32'h0, 4'hF, lat);
    do_read(MODE_REG_ADDR, lat);
    end_test("mode_reg");
  endtask

  task automatic test_sealed();
    logic [31:0] d;
    int          lat;
    for (int i = 0; i < N_ADDR; i++) begin
      do_read(used_addr[i], lat);
      rand_bits(32, d);
      do_write(used_addr[i], d, 4'hF, lat);
    end
    // Reset returns to firmware mode and keeps the contents
    do_reset();
    do_read(MODE_REG_ADDR, lat);
    for (int i = 0; i < N_ADDR; i++) begin
      do_read(used_addr[i], lat);
    end
    end_test("sealed_ram");
  endtask

  task automatic test_unmapped();
    logic [31:0] v;
    logic [31:0] d;
    axi_addr_t   a;
    int          lat;
    for (int i = 0; i < N_ADDR; i++) begin
      rand_bits(11, v);
      a = 12'h804 + axi_addr_t'(v % 32'h7FC);
      do_read(a, lat);
      rand_bits(32, d);
      do_write(a, d, 4'hF, lat);
    end
    end_test("unmapped");
  endtask

  task automatic run_backpressure();
    logic [31:0] v;
    axi_addr_t   a;
    word_t       d1;
    word_t       d3;
    logic        exp_w [4];
    resp_t       exp_r [4];
    word_t       exp_d [4];
    logic        got_w [4];
    resp_t       got_r [4];
    word_t       got_d [4];
    int          got;
    int          n;
    logic        aw_pend;
    logic        ar_pend;
    logic        take_aw;
    logic        take_ar;

    rand_ram_addr(a);
    rand_bits(32, v);
    d1 = v;
    rand_bits(32, v);
    d3 = v;
    // Expected responses in acceptance order with writes ahead of reads
    exp_w[0] = 1'b1;
    exp_d[0] = '0;
    model_write(a, d1, 4'hF, exp_r[0]);
    exp_w[1] = 1'b0;
    model_read(a, exp_d[1], exp_r[1]);
    exp_w[2] = 1'b1;
    exp_d[2] = '0;
    model_write(a, d3, 4'hF, exp_r[2]);
    exp_w[3] = 1'b0;
    model_read(a, exp_d[3], exp_r[3]);

    bready = 1'b0;
    rready = 1'b0;
    issue_write(a, d1, 4'hF);
    issue_read(a);
    // A lone read held off by the outstanding limit
    arvalid = 1'b1;
    araddr  = a;
    for (int k = 0; k < HOLD_CYCLES; k++) begin
      @(negedge clk);
      check_val("arready", 32'h0, arready);
    end
    @(posedge clk);
    #1;
    // The write is held off as well
    awvalid = 1'b1;
    wvalid  = 1'b1;
    awaddr  = a;
    wdata   = d3;
    wstrb   = 4'hF;
    for (int k = 0; k < HOLD_CYCLES; k++) begin
      @(negedge clk);
      check_val("awready", 32'h0, awready);
      check_val("wready", 32'h0, wready);
    end
    @(posedge clk);
    #1;
    bready  = 1'b1;
    rready  = 1'b1;
    aw_pend = 1'b1;
    ar_pend = 1'b1;
    got     = 0;
    n       = 0;
    while (got < 4 || aw_pend || ar_pend) begin
      @(negedge clk);
      take_aw = awready;
      take_ar = arready;
      if ((bvalid || rvalid) && got < 4) begin
        got_w[got] = bvalid;
        got_r[got] = bvalid ? bresp : rresp;
        got_d[got] = rdata;
        got++;
      end
      @(posedge clk);
      #1;
      if (take_aw) begin
        awvalid = 1'b0;
        wvalid  = 1'b0;
        aw_pend = 1'b0;
      end
      if (take_ar) begin
        arvalid = 1'b0;
        ar_pend = 1'b0;
      end
      n++;
      if (n > TIMEOUT) begin
        abort_run("responses did not drain after back-pressure");
      end
    end
    for (int i = 0; i < 4; i++) begin
      check_val($sformatf("response %0d is_write", i), exp_w[i], got_w[i]);
      check_val($sformatf("response %0d resp", i), exp_r[i], got_r[i]);
      if (!exp_w[i]) begin
        check_val($sformatf("response %0d rdata", i), exp_d[i], got_d[i]);
      end
    end
    end_test("backpressure");
  endtask

  task automatic test_latency();
    logic [31:0] d;
    axi_addr_t   a;
    int          lat;
    for (int i = 0; i < 4; i++) begin
      rand_ram_addr(a);
      rand_bits(32, d);
      do_write(a, d, 4'hF, lat);
      check_val("bvalid latency", 32'd3, lat);
      do_read(a, lat);
      check_val("rvalid latency", 32'd3, lat);
    end
    do_read(MODE_REG_ADDR, lat);
    check_val("rvalid latency", 32'd3, lat);
    end_test("latency");
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    reset_n     = 1'b0;
    awvalid     = 1'b0;
    awaddr      = '0;
    wvalid      = 1'b0;
    wdata       = '0;
    wstrb       = '0;
    bready      = 1'b1;
    arvalid     = 1'b0;
    araddr      = '0;
    rready      = 1'b1;
    lfsr        = 16'd53;
    model_mode  = 1'b0;
    checks      = 0;
    errors      = 0;
    errors_base = 0;

    do_reset();
    test_ram_rw();
    test_mode_reg();
    test_sealed();
    test_unmapped();
    run_backpressure();
    test_latency();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
verilog/fw_mem_pkg.sv
verilog/axil_req_stage.sv
verilog/access_ctrl_stage.sv
verilog/fw_ram.sv
verilog/axil_resp_stage.sv
verilog/fw_mem_top.sv
dv/fw_mem_tb.sv
